// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_regfile.sv
  - rv_decoder.sv
  - rv_alu.sv
  - rv_lsu.sv
  - rv_core.sv
  - target: simulation
    files:
      - rv_tb_mem.sv
      - rv_core_tb.sv

// ==== rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  op_e   i_op,
    input  word_t i_rs1,
    input  word_t i_rs2,
    input  imm_t  i_imm,
    input  word_t i_pc,
    output word_t o_result
);

    logic [4:0] shamt_reg;
    logic [4:0] shamt_imm;
    logic       lt_reg;
    logic       ltu_reg;
    logic       lt_imm;
    logic       ltu_imm;

    // Shift amounts only use the low five bits
    assign shamt_reg = i_rs2[4:0];
    assign shamt_imm = i_imm[4:0];

    // Comparisons for SLT and SLTU in both forms
    assign lt_reg  = $signed(i_rs1) < $signed(i_rs2);
    assign ltu_reg = i_rs1 < i_rs2;
    assign lt_imm  = $signed(i_rs1) < $signed(i_imm);
    assign ltu_imm = i_rs1 < i_imm;

    always_comb begin
        case (i_op)
            OP_ADD:   o_result = i_rs1 + i_rs2;
            OP_SUB:   o_result = i_rs1 - i_rs2;
            OP_AND:   o_result = i_rs1 & i_rs2;
            OP_OR:    o_result = i_rs1 | i_rs2;
            OP_XOR:   o_result = i_rs1 ^ i_rs2;
            OP_SLL:   o_result = i_rs1 << shamt_reg;
            OP_SRL:   o_result = i_rs1 >> shamt_reg;
            OP_SRA:   o_result = word_t'($signed(i_rs1) >>> shamt_reg);
            OP_SLT:   o_result = word_t'(lt_reg);
            OP_SLTU:  o_result = word_t'(ltu_reg);
            OP_ADDI:  o_result = i_rs1 + i_imm;
            OP_ANDI:  o_result = i_rs1 & i_imm;
            OP_ORI:   o_result = i_rs1 | i_imm;
            OP_XORI:  o_result = i_rs1 ^ i_imm;
            OP_SLLI:  o_result = i_rs1 << shamt_imm;
            OP_SRLI:  o_result = i_rs1 >> shamt_imm;
            OP_SRAI:  o_result = word_t'($signed(i_rs1) >>> shamt_imm);
            OP_SLTI:  o_result = word_t'(lt_imm);
            OP_SLTIU: o_result = word_t'(ltu_imm);
            // Effective address for every load and store
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW: begin
                o_result = i_rs1 + i_imm;
            end
            OP_LUI:   o_result = i_imm;
            OP_AUIPC: o_result = i_pc + i_imm;
            default:  o_result = '0;
        endcase
    end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic   clk,
    input  logic   reset,
    // Instruction port
    output logic   o_imem_valid,
    output word_t  o_imem_addr,
    input  logic   i_imem_valid,
    input  word_t  i_imem_data,
    // Data port
    output logic   o_dmem_valid,
    output word_t  o_dmem_addr,
    output word_t  o_dmem_wdata,
    output lanes_t o_dmem_read_lanes,
    output lanes_t o_dmem_write_lanes,
    input  logic   i_dmem_valid,
    input  word_t  i_dmem_rdata
);

    stage_e   stage;
    word_t    pc;
    word_t    instr_q;
    logic     imem_req_q;
    word_t    result_q;
    reg_idx_t rd_q;
    word_t    store_data_q;

    op_e      dec_op;
    reg_idx_t dec_rs1_idx;
    reg_idx_t dec_rs2_idx;
    reg_idx_t dec_rd_idx;
    imm_t     dec_imm;
    logic     dec_writes_rd;
    logic     dec_is_load;
    logic     dec_is_store;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;
    lanes_t   lsu_lanes;
    word_t    lsu_wdata;
    word_t    load_value;
    logic     mem_access;
    logic     rf_we;

    assign mem_access = dec_is_load || dec_is_store;
    assign rf_we      = (stage == ST_WRITEBACK) && dec_writes_rd;

    rv_decoder i_rv_decoder (
        .i_instr     (instr_q),
        .o_op        (dec_op),
        .o_rs1_idx   (dec_rs1_idx),
        .o_rs2_idx   (dec_rs2_idx),
        .o_rd_idx    (dec_rd_idx),
        .o_imm       (dec_imm),
        .o_writes_rd (dec_writes_rd),
        .o_is_load   (dec_is_load),
        .o_is_store  (dec_is_store)
    );

    // Indices are presented in decode, data is used in execute
    rv_regfile i_rv_regfile (
        .clk        (clk),
        .reset      (reset),
        .i_rs1_idx  (dec_rs1_idx),
        .i_rs2_idx  (dec_rs2_idx),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_rd_idx   (rd_q),
        .i_rd_data  (result_q),
        .i_rd_we    (rf_we)
    );

    rv_alu i_rv_alu (
        .i_op     (dec_op),
        .i_rs1    (rs1_data),
        .i_rs2    (rs2_data),
        .i_imm    (dec_imm),
        .i_pc     (pc),
        .o_result (alu_result)
    );

    // result_q holds the effective address during the memory stage
    rv_lsu i_rv_lsu (
        .i_op         (dec_op),
        .i_addr       (result_q),
        .i_store_data (store_data_q),
        .i_rdata      (i_dmem_rdata),
        .o_lanes      (lsu_lanes),
        .o_wdata      (lsu_wdata),
        .o_load_value (load_value)
    );

    // Stage machine, PC and fetch request
    always_ff @(posedge clk) begin
        if (reset) begin
            stage      <= ST_FETCH;
            pc         <= RESET_PC;
            instr_q    <= '0;
            imem_req_q <= 1'b0;
        end else begin
            case (stage)
                ST_FETCH: begin
                    if (i_imem_valid) begin
                        instr_q    <= i_imem_data;
                        imem_req_q <= 1'b0;
                        stage      <= ST_DECODE;
                    end else begin
                        imem_req_q <= 1'b1;
                    end
                end
                ST_DECODE:  stage <= ST_EXECUTE;
                ST_EXECUTE: stage <= ST_MEM;
                ST_MEM: begin
                    // Loads and stores wait here for the data response
                    if (!mem_access || i_dmem_valid) begin
                        stage <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: begin
                    pc         <= pc + 32'd4;
                    imem_req_q <= 1'b1;
                    stage      <= ST_FETCH;
                end
                default: stage <= ST_FETCH;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (stage == ST_EXECUTE) begin
            result_q     <= alu_result;
            rd_q         <= dec_rd_idx;
            store_data_q <= rs2_data;
        end else if (stage == ST_MEM && dec_is_load && i_dmem_valid) begin
            result_q <= load_value;
        end
    end

    assign o_imem_valid = imem_req_q;
    assign o_imem_addr  = pc;

    assign o_dmem_valid       = (stage == ST_MEM) && mem_access;
    assign o_dmem_addr        = {result_q[XLEN-1:2], 2'b00};
    assign o_dmem_wdata       = dec_is_store ? lsu_wdata : '0;
    assign o_dmem_read_lanes  = dec_is_load ? lsu_lanes : '0;
    assign o_dmem_write_lanes = dec_is_store ? lsu_lanes : '0;

endmodule

// ==== rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

    localparam word_t RESET_PC = 32'h0000_0100;

    logic   clk = 1'b0;
    logic   reset = 1'b1;
    logic   imem_req, imem_rsp, dmem_req, dmem_rsp;
    word_t  imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
    lanes_t dmem_rlanes, dmem_wlanes;
    logic   wr_valid;
    word_t  wr_addr, wr_data;
    lanes_t wr_lanes;

    word_t  prog[$];
    word_t  pre[word_t];
    word_t  mreg[32];
    word_t  exp_addr[$], exp_data[$];
    lanes_t exp_lanes[$];
    word_t  exp_req_addr[$];
    lanes_t exp_rlanes[$];
    int     wr_count = 0;
    int     req_count = 0;
    int     slot = 0;
    logic   first_fetch = 1'b1;
    word_t  last_fetch;
    logic   imem_req_q = 1'b0, imem_rsp_q = 1'b0, dmem_req_q = 1'b0, dmem_rsp_q = 1'b0;
    word_t  imem_addr_q, dmem_addr_q, dmem_wdata_q;
    lanes_t dmem_wlanes_q, dmem_rlanes_q;

    always #4 clk = ~clk;

    rv_core #(.RESET_PC(RESET_PC)) i_rv_core (
        .clk(clk), .reset(reset),
        .o_imem_valid(imem_req), .o_imem_addr(imem_addr),
        .i_imem_valid(imem_rsp), .i_imem_data(imem_data),
        .o_dmem_valid(dmem_req), .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata),
        .o_dmem_read_lanes(dmem_rlanes), .o_dmem_write_lanes(dmem_wlanes),
        .i_dmem_valid(dmem_rsp), .i_dmem_rdata(dmem_rdata)
    );

    rv_tb_mem i_rv_tb_mem (
        .clk(clk),
        .i_imem_valid(imem_req), .i_imem_addr(imem_addr),
        .o_imem_valid(imem_rsp), .o_imem_data(imem_data),
        .i_dmem_valid(dmem_req), .i_dmem_addr(dmem_addr), .i_dmem_wdata(dmem_wdata),
        .i_dmem_write_lanes(dmem_wlanes),
        .o_dmem_valid(dmem_rsp), .o_dmem_rdata(dmem_rdata),
        .o_wr_valid(wr_valid), .o_wr_addr(wr_addr), .o_wr_lanes(wr_lanes), .o_wr_data(wr_data)
    );

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic word_t byte_mask(input lanes_t l);
        word_t m;
        for (int i = 0; i < 4; i++) m[8*i +: 8] = {8{l[i]}};
        return m;
    endfunction

    // Reference arithmetic straight from the RV32I definitions
    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // All stores and data requests seen and the fetch moved past the last instruction
    function automatic logic program_done();
        return wr_count == exp_addr.size() && req_count == exp_rlanes.size()
               && last_fetch === RESET_PC + 4 * prog.size();
    endfunction

    task automatic set_reg(input int rd, input word_t v);
        if (rd != 0) mreg[rd] = v;
    endtask

    task automatic rop(input logic [2:0] f3, input logic alt, input int rd, rs1, rs2);
        prog.push_back({alt ? 7'h20 : 7'h00, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33});
        set_reg(rd, ref_alu(f3, alt, mreg[rs1], mreg[rs2]));
    endtask

    task automatic iop(input logic [2:0] f3, input int rd, rs1, input logic [11:0] imm);
        prog.push_back({imm, 5'(rs1), f3, 5'(rd), 7'h13});
        set_reg(rd, ref_alu(f3, f3 == 3'd5 && imm[10], mreg[rs1], sext12(imm)));
    endtask

    task automatic upper(input logic pc_rel, input int rd, input logic [19:0] imm);
        prog.push_back({imm, 5'(rd), pc_rel ? 7'h17 : 7'h37});
        set_reg(rd, {imm, 12'h000} + (pc_rel ? RESET_PC + 4 * (prog.size() - 1) : 0));
    endtask

    task automatic st(input logic [2:0] f3, input int rs2, rs1, input logic [11:0] imm);
        word_t ea;
        ea = mreg[rs1] + sext12(imm);
        prog.push_back({imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'h23});
        exp_addr.push_back({ea[31:2], 2'b00});
        exp_req_addr.push_back({ea[31:2], 2'b00});
        exp_rlanes.push_back(4'b0000);
        case (f3)
            3'd0: begin
                exp_lanes.push_back(4'b0001 << ea[1:0]);
                exp_data.push_back(mreg[rs2] << (8 * ea[1:0]));
            end
            3'd1: begin
                exp_lanes.push_back(ea[1] ? 4'b1100 : 4'b0011);
                exp_data.push_back(mreg[rs2] << (16 * ea[1]));
            end
            default: begin
                exp_lanes.push_back(4'b1111);
                exp_data.push_back(mreg[rs2]);
            end
        endcase
    endtask

    task automatic ld(input logic [2:0] f3, input int rd, rs1, input logic [11:0] imm);
        word_t ea, w;
        ea = mreg[rs1] + sext12(imm);
        w  = pre[{ea[31:2], 2'b00}];
        prog.push_back({imm, 5'(rs1), f3, 5'(rd), 7'h03});
        exp_req_addr.push_back({ea[31:2], 2'b00});
        case (f3)
            3'd0, 3'd4: exp_rlanes.push_back(4'b0001 << ea[1:0]);
            3'd1, 3'd5: exp_rlanes.push_back(ea[1] ? 4'b1100 : 4'b0011);
            default:    exp_rlanes.push_back(4'b1111);
        endcase
        case (f3)
            3'd0: set_reg(rd, {{24{w[8*ea[1:0]+7]}}, w[8*ea[1:0] +: 8]});
            3'd4: set_reg(rd, {24'h0, w[8*ea[1:0] +: 8]});
            3'd1: set_reg(rd, {{16{w[16*ea[1]+15]}}, w[16*ea[1] +: 16]});
            3'd5: set_reg(rd, {16'h0, w[16*ea[1] +: 16]});
            default: set_reg(rd, w);
        endcase
    endtask

    task automatic save(input int rs);
        st(3'd2, rs, 1, 12'(slot));
        slot += 4;
    endtask

    task automatic build_program();
        logic [2:0] imm_f3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        pre[32'h1400] = 32'h80f1_7f02;
        pre[32'h1404] = 32'h7f80_ff01;
        // x1 is the store area, x9 the preloaded load area
        upper(1'b0, 1, 20'h00001);
        upper(1'b0, 9, 20'h00001);
        iop(3'd0, 9, 9, 12'h400);
        upper(1'b0, 2, 20'h87654);
        iop(3'd0, 2, 2, 12'h321);
        iop(3'd0, 3, 0, 12'hff9);
        iop(3'd0, 4, 0, 12'd13);
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 0 || f == 5) begin
                    rop(3'(f), alt[0], 5, 2, 4);
                    save(5);
                    rop(3'(f), alt[0], 5, 3, 2);
                    save(5);
                end
            end
        end
        foreach (imm_f3[k]) begin
            iop(imm_f3[k], 5, 2, 12'hff9);
            save(5);
            iop(imm_f3[k], 5, 3, 12'h5a3);
            save(5);
        end
        // Shifts by immediate, bit 10 picks SRAI
        iop(3'd1, 5, 2, 12'h004);
        save(5);
        iop(3'd1, 5, 3, 12'h01f);
        save(5);
        iop(3'd5, 5, 3, 12'h004);
        save(5);
        iop(3'd5, 5, 3, 12'h41f);
        save(5);
        iop(3'd5, 5, 2, 12'h41f);
        save(5);
        upper(1'b1, 5, 20'h12345);
        save(5);
        iop(3'd0, 0, 4, 12'd99);
        save(0);
        for (int k = 0; k < 4; k++) st(3'd0, 2, 1, 12'(slot + k));
        slot += 4;
        st(3'd1, 2, 1, 12'(slot));
        st(3'd1, 3, 1, 12'(slot + 2));
        slot += 4;
        for (int w = 0; w < 8; w += 4) begin
            for (int k = 0; k < 4; k++) begin
                ld(3'd0, 6, 9, 12'(w + k));
                save(6);
                ld(3'd4, 6, 9, 12'(w + k));
                save(6);
            end
            for (int k = 0; k < 4; k += 2) begin
                ld(3'd1, 6, 9, 12'(w + k));
                save(6);
                ld(3'd5, 6, 9, 12'(w + k));
                save(6);
            end
            ld(3'd2, 6, 9, 12'(w));
            save(6);
        end
        // Trailing no-op that must retire before the run ends
        iop(3'd0, 0, 0, 12'h000);
    endtask

    // Port monitor, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (reset) begin
            assert (!imem_req && !dmem_req) else fail_now("A request was valid during reset");
        end else begin
            if (imem_req_q && !imem_rsp_q) begin
                assert (imem_req && imem_addr === imem_addr_q)
                    else fail_now("Fetch request changed before its response");
            end else if (imem_req) begin
                check_value("o_imem_addr", imem_addr, first_fetch ? RESET_PC : last_fetch + 4);
                last_fetch  = imem_addr;
                first_fetch = 1'b0;
            end
            if (dmem_req_q && !dmem_rsp_q) begin
                assert (dmem_req && dmem_addr === dmem_addr_q && dmem_wlanes === dmem_wlanes_q
                        && dmem_rlanes === dmem_rlanes_q && dmem_wdata === dmem_wdata_q)
                    else fail_now("Data request changed before its response");
            end else if (dmem_req) begin
                // Each new data request is the program's next load or store
                assert (req_count < exp_rlanes.size()) else fail_now("Unexpected data request");
                check_value("o_dmem_addr", dmem_addr, exp_req_addr[req_count]);
                check_value("o_dmem_read_lanes", dmem_rlanes, exp_rlanes[req_count]);
                req_count++;
            end
            if (wr_valid) begin
                assert (wr_count < exp_addr.size()) else fail_now("Unexpected store to memory");
                check_value("o_dmem_addr", wr_addr, exp_addr[wr_count]);
                check_value("o_dmem_write_lanes", wr_lanes, exp_lanes[wr_count]);
                check_value("o_dmem_wdata", wr_data & byte_mask(wr_lanes),
                            exp_data[wr_count] & byte_mask(exp_lanes[wr_count]));
                wr_count++;
            end
        end
        imem_req_q    = imem_req;
        imem_rsp_q    = imem_rsp;
        imem_addr_q   = imem_addr;
        dmem_req_q    = dmem_req;
        dmem_rsp_q    = dmem_rsp;
        dmem_addr_q   = dmem_addr;
        dmem_wlanes_q = dmem_wlanes;
        dmem_rlanes_q = dmem_rlanes;
        dmem_wdata_q  = dmem_wdata;
    end

    initial begin
        int cycles;
        void'($urandom(32'ha192_e976));
        foreach (mreg[i]) mreg[i] = '0;
        build_program();
        repeat (2) @(posedge clk);
        foreach (prog[i]) i_rv_tb_mem.load_word(RESET_PC + 4 * i, prog[i]);
        foreach (pre[a]) i_rv_tb_mem.load_word(a, pre[a]);
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (!program_done() && cycles < 40000) begin
            @(posedge clk);
            cycles++;
        end
        if (program_done()) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Timed out waiting for the program to finish");
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
    input  word_t    i_instr,
    output op_e      o_op,
    output reg_idx_t o_rs1_idx,
    output reg_idx_t o_rs2_idx,
    output reg_idx_t o_rd_idx,
    output imm_t     o_imm,
    output logic     o_writes_rd,
    output logic     o_is_load,
    output logic     o_is_store
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    f7_base;
    logic    f7_alt;
    imm_t    imm_i;
    imm_t    imm_s;
    imm_t    imm_u;

    assign opcode  = i_instr[6:0];
    assign funct3  = i_instr[14:12];
    assign funct7  = i_instr[31:25];
    assign f7_base = (funct7 == FUNCT7_BASE);
    assign f7_alt  = (funct7 == FUNCT7_ALT);

    // Immediate formats
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_u = {i_instr[31:12], 12'b0};

    // rd sits in the same field for every format that writes it
    assign o_rd_idx = i_instr[11:7];

    always_comb begin
        o_op      = OP_NONE;
        o_rs1_idx = '0;
        o_rs2_idx = '0;
        o_imm     = '0;
        case (opcode)
            OPCODE_R_TYPE: begin
                o_rs1_idx = i_instr[19:15];
                o_rs2_idx = i_instr[24:20];
                case (funct3)
                    FUNCT3_ADD_SUB: o_op = f7_base ? OP_ADD : (f7_alt ? OP_SUB : OP_NONE);
                    FUNCT3_SLL:     o_op = f7_base ? OP_SLL : OP_NONE;
                    FUNCT3_SLT:     o_op = f7_base ? OP_SLT : OP_NONE;
                    FUNCT3_SLTU:    o_op = f7_base ? OP_SLTU : OP_NONE;
                    FUNCT3_XOR:     o_op = f7_base ? OP_XOR : OP_NONE;
                    FUNCT3_SRL_SRA: o_op = f7_base ? OP_SRL : (f7_alt ? OP_SRA : OP_NONE);
                    FUNCT3_OR:      o_op = f7_base ? OP_OR : OP_NONE;
                    default:        o_op = f7_base ? OP_AND : OP_NONE;
                endcase
            end
            OPCODE_IMM: begin
                o_rs1_idx = i_instr[19:15];
                o_imm     = imm_i;
                case (funct3)
                    FUNCT3_ADD_SUB: o_op = OP_ADDI;
                    FUNCT3_SLL:     o_op = f7_base ? OP_SLLI : OP_NONE;
                    FUNCT3_SLT:     o_op = OP_SLTI;
                    FUNCT3_SLTU:    o_op = OP_SLTIU;
                    FUNCT3_XOR:     o_op = OP_XORI;
                    FUNCT3_SRL_SRA: o_op = f7_base ? OP_SRLI : (f7_alt ? OP_SRAI : OP_NONE);
                    FUNCT3_OR:      o_op = OP_ORI;
                    default:        o_op = OP_ANDI;
                endcase
            end
            OPCODE_LOAD: begin
                o_rs1_idx = i_instr[19:15];
                o_imm     = imm_i;
                case (funct3)
                    FUNCT3_LB:  o_op = OP_LB;
                    FUNCT3_LH:  o_op = OP_LH;
                    FUNCT3_LW:  o_op = OP_LW;
                    FUNCT3_LBU: o_op = OP_LBU;
                    FUNCT3_LHU: o_op = OP_LHU;
                    default:    o_op = OP_NONE;
                endcase
            end
            OPCODE_STORE: begin
                o_rs1_idx = i_instr[19:15];
                o_rs2_idx = i_instr[24:20];
                o_imm     = imm_s;
                case (funct3)
                    FUNCT3_SB: o_op = OP_SB;
                    FUNCT3_SH: o_op = OP_SH;
                    FUNCT3_SW: o_op = OP_SW;
                    default:   o_op = OP_NONE;
                endcase
            end
            OPCODE_LUI: begin
                o_op  = OP_LUI;
                o_imm = imm_u;
            end
            OPCODE_AUIPC: begin
                o_op  = OP_AUIPC;
                o_imm = imm_u;
            end
            // Branches, jumps and anything else fall through as a no-op
            default: o_op = OP_NONE;
        endcase
    end

    assign o_is_load   = o_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    assign o_is_store  = o_op inside {OP_SB, OP_SH, OP_SW};
    assign o_writes_rd = (o_op != OP_NONE) && !o_is_store;

endmodule

// ==== rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
    input  op_e    i_op,
    input  word_t  i_addr,
    input  word_t  i_store_data,
    input  word_t  i_rdata,
    output lanes_t o_lanes,
    output word_t  o_wdata,
    output word_t  o_load_value
);

    logic       is_byte;
    logic       is_half;
    logic       is_word;
    logic [1:0] byte_shift;
    logic [4:0] bit_shift;
    word_t      rdata_low;

    assign is_byte = i_op inside {OP_LB, OP_LBU, OP_SB};
    assign is_half = i_op inside {OP_LH, OP_LHU, OP_SH};
    assign is_word = i_op inside {OP_LW, OP_SW};

    // Halfwords only look at bit 1, words ignore the offset entirely
    always_comb begin
        if (is_byte) begin
            byte_shift = i_addr[1:0];
            o_lanes    = lanes_t'(4'b0001 << i_addr[1:0]);
        end else if (is_half) begin
            byte_shift = {i_addr[1], 1'b0};
            o_lanes    = i_addr[1] ? 4'b1100 : 4'b0011;
        end else if (is_word) begin
            byte_shift = 2'd0;
            o_lanes    = 4'b1111;
        end else begin
            byte_shift = 2'd0;
            o_lanes    = 4'b0000;
        end
    end

    assign bit_shift = {byte_shift, 3'b000};

    // Store data moves up into the selected lanes
    assign o_wdata = i_store_data << bit_shift;

    // Read data moves down to the low bytes before extension
    assign rdata_low = i_rdata >> bit_shift;

    always_comb begin
        case (i_op)
            OP_LB:   o_load_value = {{24{rdata_low[7]}}, rdata_low[7:0]};
            OP_LBU:  o_load_value = {24'b0, rdata_low[7:0]};
            OP_LH:   o_load_value = {{16{rdata_low[15]}}, rdata_low[15:0]};
            OP_LHU:  o_load_value = {16'b0, rdata_low[15:0]};
            default: o_load_value = rdata_low;
        endcase
    end

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

    // Core widths
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    typedef logic [XLEN/8-1:0]           lanes_t;
    typedef logic [XLEN-1:0]             imm_t;
    typedef logic [6:0]                  opcode_t;
    typedef logic [2:0]                  funct3_t;
    typedef logic [6:0]                  funct7_t;

    // Major opcodes handled by this core
    localparam opcode_t OPCODE_R_TYPE = 7'b0110011;
    localparam opcode_t OPCODE_IMM    = 7'b0010011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;

    // ALU funct3, shared by the register and immediate forms
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL     = 3'b001;
    localparam funct3_t FUNCT3_SLT     = 3'b010;
    localparam funct3_t FUNCT3_SLTU    = 3'b011;
    localparam funct3_t FUNCT3_XOR     = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR      = 3'b110;
    localparam funct3_t FUNCT3_AND     = 3'b111;

    // Load and store access sizes
    localparam funct3_t FUNCT3_LB  = 3'b000;
    localparam funct3_t FUNCT3_LH  = 3'b001;
    localparam funct3_t FUNCT3_LW  = 3'b010;
    localparam funct3_t FUNCT3_LBU = 3'b100;
    localparam funct3_t FUNCT3_LHU = 3'b101;
    localparam funct3_t FUNCT3_SB  = 3'b000;
    localparam funct3_t FUNCT3_SH  = 3'b001;
    localparam funct3_t FUNCT3_SW  = 3'b010;

    // funct7 selects SUB and SRA / SRAI
    localparam funct7_t FUNCT7_BASE = 7'h00;
    localparam funct7_t FUNCT7_ALT  = 7'h20;

    // Decoded operation
    typedef enum logic [4:0] {
        OP_NONE,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_LUI, OP_AUIPC
    } op_e;

    // One instruction walks through these in order
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEM,
        ST_WRITEBACK
    } stage_e;

endpackage

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t i_rs1_idx,
    input  reg_idx_t i_rs2_idx,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data,
    input  reg_idx_t i_rd_idx,
    input  word_t    i_rd_data,
    input  logic     i_rd_we
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            o_rs1_data <= '0;
            o_rs2_data <= '0;
        end else begin
            // x0 is hardwired, so writes to it are dropped
            if (i_rd_we && i_rd_idx != '0) begin
                regs[i_rd_idx] <= i_rd_data;
            end
            // Registered reads, data valid one cycle after the index
            o_rs1_data <= (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
            o_rs2_data <= (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];
        end
    end

endmodule

// ==== rv_tb_mem.sv ====
`timescale 1ns/1ps

module rv_tb_mem import rv_pkg::*; (
    input  logic   clk,
    input  logic   i_imem_valid,
    input  word_t  i_imem_addr,
    output logic   o_imem_valid,
    output word_t  o_imem_data,
    input  logic   i_dmem_valid,
    input  word_t  i_dmem_addr,
    input  word_t  i_dmem_wdata,
    input  lanes_t i_dmem_write_lanes,
    output logic   o_dmem_valid,
    output word_t  o_dmem_rdata,
    output logic   o_wr_valid,
    output word_t  o_wr_addr,
    output lanes_t o_wr_lanes,
    output word_t  o_wr_data
);

    word_t mem [2048];
    int    imem_wait;
    int    dmem_wait;
    logic  imem_busy;
    logic  dmem_busy;

    initial begin
        // Background words carry their own byte address
        for (int i = 0; i < 2048; i++) begin
            mem[i] = (i * 4) ^ 32'h5a5a_0000;
        end
        imem_busy    = 1'b0;
        dmem_busy    = 1'b0;
        o_imem_valid = 1'b0;
        o_imem_data  = '0;
        o_dmem_valid = 1'b0;
        o_dmem_rdata = '0;
        o_wr_valid   = 1'b0;
        o_wr_addr    = '0;
        o_wr_lanes   = '0;
        o_wr_data    = '0;
    end

    task automatic load_word(input word_t addr, input word_t data);
        mem[addr[12:2]] = data;
    endtask

    // Instruction port, response after 0 to 3 idle cycles
    always @(posedge clk) begin
        if (o_imem_valid) begin
            o_imem_valid <= 1'b0;
            imem_busy = 1'b0;
        end else if (i_imem_valid) begin
            if (!imem_busy) begin
                imem_busy = 1'b1;
                imem_wait = $urandom % 4;
            end
            if (imem_wait == 0) begin
                o_imem_valid <= 1'b1;
                o_imem_data  <= mem[i_imem_addr[12:2]];
            end else begin
                imem_wait--;
            end
        end
    end

    // Data port, stores are applied and reported when answered
    always @(posedge clk) begin
        o_wr_valid <= 1'b0;
        if (o_dmem_valid) begin
            o_dmem_valid <= 1'b0;
            dmem_busy = 1'b0;
        end else if (i_dmem_valid) begin
            if (!dmem_busy) begin
                dmem_busy = 1'b1;
                dmem_wait = $urandom % 4;
            end
            if (dmem_wait == 0) begin
                o_dmem_valid <= 1'b1;
                o_dmem_rdata <= mem[i_dmem_addr[12:2]];
                if (i_dmem_write_lanes != '0) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_dmem_write_lanes[b]) begin
                            mem[i_dmem_addr[12:2]][8*b +: 8] = i_dmem_wdata[8*b +: 8];
                        end
                    end
                    o_wr_valid <= 1'b1;
                    o_wr_addr  <= i_dmem_addr;
                    o_wr_lanes <= i_dmem_write_lanes;
                    o_wr_data  <= i_dmem_wdata;
                end
            end else begin
                dmem_wait--;
            end
        end
    end

endmodule

// ==== sources.f ====
rv_pkg.sv
rv_regfile.sv
rv_decoder.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
rv_tb_mem.sv
rv_core_tb.sv
